/* voltmeter.f */
logic/vga_pkg.sv
logic/vga_timing.sv
logic/vga_regs.sv
logic/draw_background.sv
logic/draw_rect.sv
logic/voltmeter_top.sv
test/voltmeter_asserts.sv
test/voltmeter_tb.sv

/* Bender.yml */
package:
  name: voltmeter

sources:
  # RTL in compile order
  - files:
      - logic/vga_pkg.sv
      - logic/vga_timing.sv
      - logic/vga_regs.sv
      - logic/draw_background.sv
      - logic/draw_rect.sv
      - logic/voltmeter_top.sv

  # testbench and bound checker
  - target: test
    files:
      - test/voltmeter_asserts.sv
      - test/voltmeter_tb.sv

/* test/voltmeter_tb.sv */
module voltmeter_tb import vga_pkg::*; ();

  // small raster, 24 cycles per line and 15 lines per frame
  localparam int H_ACTIVE   = 16;
  localparam int H_FRONT    = 2;
  localparam int H_SYNC     = 3;
  localparam int H_BACK     = 3;
  localparam int V_ACTIVE   = 10;
  localparam int V_FRONT    = 1;
  localparam int V_SYNC     = 2;
  localparam int V_BACK     = 2;
  localparam int FRAME      = 360;
  localparam int HS_TIMEOUT = 40;
  localparam int VS_TIMEOUT = 2 * FRAME;

  logic        pclk;
  logic        rst;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        hs;
  logic        vs;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;

  // expected register contents: ctrl, bg, pos, size, rect colour
  logic [31:0] shadow [5];
  logic [31:0] rng_state;
  logic [31:0] rnd;
  int          i;
  int          x;
  int          y;
  int          w;
  int          h;

  voltmeter_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) dut_i (
    .pclk     (pclk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .hs       (hs),
    .vs       (vs),
    .r        (r),
    .g        (g),
    .b        (b)
  );

  always #2 pclk = ~pclk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // any failing bound assertion ends the run
  always @(dut_i.asserts_i.fail_count) begin
    if (dut_i.asserts_i.fail_count != 0) begin
      stop_with_failure("a concurrent assertion failed");
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // slot of a mapped address, -1 outside the map
  function automatic int reg_index(input logic [7:0] addr);
    if (addr[1:0] != 2'b00 || addr > REG_RECT_COLOR) return -1;
    return int'(addr[7:2]);
  endfunction

  // implemented bits of each register
  function automatic logic [31:0] field_mask(input int idx);
    case (idx)
      0:       return 32'h0000_0001;
      2:       return 32'h0FFF_0FFF;
      3:       return 32'h003F_003F;
      default: return 32'h0000_0FFF;
    endcase
  endfunction

  function automatic logic rsp_bit(input int which);
    case (which)
      0:       return axil_rsp.aw_ready;
      1:       return axil_rsp.b_valid;
      2:       return axil_rsp.ar_ready;
      default: return axil_rsp.r_valid;
    endcase
  endfunction

  task automatic wait_rsp(input int which, input string name);
    int n;
    for (n = 0; !rsp_bit(which); n++) begin
      if (n == HS_TIMEOUT) stop_with_failure({"timeout waiting for ", name});
      @(posedge pclk);
      #1;
    end
  endtask

  task automatic wait_vs_fall();
    logic prev;
    int   n;
    prev = vs;
    for (n = 0; n < VS_TIMEOUT; n++) begin
      @(posedge pclk);
      #1;
      if (prev && !vs) return;
      prev = vs;
    end
    stop_with_failure("timeout waiting for vs to fall");
  endtask

  task automatic run_frames(input int count);
    int k;
    for (k = 0; k < count; k++) begin
      wait_vs_fall();
    end
  endtask

  // hold delays b_ready by that many cycles
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold);
    int          idx;
    logic [31:0] lanes;
    logic [1:0]  exp_resp;
    idx      = reg_index(addr);
    exp_resp = (idx < 0) ? RESP_SLVERR : RESP_OKAY;
    lanes    = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    axil_req.aw_addr  = addr;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    axil_req.aw_valid = 1'b1;
    axil_req.w_valid  = 1'b1;
    wait_rsp(0, "aw_ready");
    // accepted on this edge
    @(posedge pclk);
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    wait_rsp(1, "b_valid");
    repeat (hold) begin
      @(posedge pclk);
      #1;
    end
    if (axil_rsp.b_resp !== exp_resp) begin
      stop_with_failure($sformatf("mismatch b_resp got %h expected %h",
                                  axil_rsp.b_resp, exp_resp));
    end
    axil_req.b_ready = 1'b1;
    @(posedge pclk);
    #1;
    axil_req.b_ready = 1'b0;
    if (idx >= 0) begin
      shadow[idx] = ((shadow[idx] & ~lanes) | (data & lanes)) & field_mask(idx);
    end
  endtask

  task automatic axil_read(input logic [7:0] addr, input int hold);
    int          idx;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    idx      = reg_index(addr);
    exp_data = (idx < 0) ? 32'h0 : shadow[idx];
    exp_resp = (idx < 0) ? RESP_SLVERR : RESP_OKAY;
    axil_req.ar_addr  = addr;
    axil_req.ar_valid = 1'b1;
    wait_rsp(2, "ar_ready");
    @(posedge pclk);
    #1;
    axil_req.ar_valid = 1'b0;
    wait_rsp(3, "r_valid");
    repeat (hold) begin
      @(posedge pclk);
      #1;
    end
    if (axil_rsp.r_data !== exp_data) begin
      stop_with_failure($sformatf("mismatch r_data got %h expected %h",
                                  axil_rsp.r_data, exp_data));
    end
    if (axil_rsp.r_resp !== exp_resp) begin
      stop_with_failure($sformatf("mismatch r_resp got %h expected %h",
                                  axil_rsp.r_resp, exp_resp));
    end
    axil_req.r_ready = 1'b1;
    @(posedge pclk);
    #1;
    axil_req.r_ready = 1'b0;
  endtask

  initial begin
    pclk      = 1'b0;
    rst       = 1'b1;
    axil_req  = '0;
    rng_state = 32'h90aed3fb;
    shadow    = '{32'h0, 32'h036, 32'h0, 32'h0, 32'hF00};
    repeat (5) @(posedge pclk);
    #1;
    rst = 1'b0;
    // reset picture, border and teal background
    run_frames(3);
    wait_vs_fall();
    axil_write(REG_BG_COLOR, next_random(), 4'hF, 0);
    axil_read(REG_BG_COLOR, 1);
    run_frames(3);
    // random rectangles, first one on the top-left border
    for (i = 0; i < 3; i++) begin
      wait_vs_fall();
      rnd = next_random();
      x   = (i == 0) ? 0 : int'(rnd[3:0]);
      y   = (i == 0) ? 0 : int'(rnd[11:8]) % V_ACTIVE;
      w   = int'(rnd[18:16]) + 1;
      h   = int'(rnd[26:24]) + 1;
      axil_write(REG_RECT_POS, 32'((y << 16) | x), 4'hF, i);
      axil_write(REG_RECT_SIZE, 32'((h << 16) | w), 4'hF, 0);
      axil_write(REG_RECT_COLOR, next_random(), 4'hF, 0);
      axil_write(REG_CTRL, 32'h1, 4'hF, 1);
      axil_read(REG_RECT_POS, 2);
      axil_read(REG_RECT_SIZE, 0);
      run_frames(3);
    end
    // zero width, nothing drawn
    wait_vs_fall();
    axil_write(REG_RECT_SIZE, 32'h0003_0000, 4'hF, 0);
    run_frames(3);
    // partial strobes and unmapped addresses
    wait_vs_fall();
    axil_write(REG_RECT_POS, next_random(), 4'b0101, 2);
    axil_write(REG_BG_COLOR, next_random(), 4'b0010, 0);
    axil_write(8'h14, 32'hFFFF_FFFF, 4'hF, 1);
    axil_write(8'h06, 32'hFFFF_FFFF, 4'hF, 0);
    axil_read(8'h14, 3);
    axil_read(8'h02, 0);
    for (i = 0; i < 5; i++) begin
      axil_read(8'(4 * i), i);
    end
    run_frames(3);
    if (dut_i.asserts_i.fail_count != 0) begin
      stop_with_failure("assertion failures were recorded");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* test/voltmeter_asserts.sv */
module voltmeter_asserts import vga_pkg::*; #(
  parameter int H_ACTIVE = 800,
  parameter int H_FRONT  = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BACK   = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BACK   = 23
) (
  input logic       pclk,
  input logic       rst,
  input axil_req_t  axil_req,
  input axil_rsp_t  axil_rsp,
  input logic       hs,
  input logic       vs,
  input logic [3:0] r,
  input logic [3:0] g,
  input logic [3:0] b
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  // distance from sync rise to first active column or line
  localparam int H_LEAD  = H_SYNC + H_BACK;
  localparam int V_LEAD  = V_SYNC + V_BACK;

  // bumped by every failing assertion, watched by the testbench
  int unsigned fail_count;

  logic        hs_q;
  logic        vs_q;
  logic        h_seen_q;
  logic        v_seen_q;
  int          hcnt_q;
  int          lcnt_q;
  int          hcnt;
  int          lcnt;
  logic        h_ok;
  logic        v_ok;
  logic        line_start;
  int          x;
  int          y;
  int          rx;
  int          ry;
  int          rw;
  int          rh;
  logic        active;
  logic        border;
  logic        hit;
  rgb_t        exp_color;
  // register images: ctrl, bg, pos, size, rect colour
  logic [31:0] stage_w [5];
  logic [31:0] act_w [5];
  logic [31:0] lanes;
  logic [31:0] field;
  int          wr_idx;

  // raster position reconstructed from the sync outputs
  always_comb begin
    hcnt       = (hs && !hs_q) ? 0 : hcnt_q + 1;
    line_start = (hcnt == H_LEAD);
    lcnt       = (vs && !vs_q) ? 0 : (line_start ? lcnt_q + 1 : lcnt_q);
    h_ok       = h_seen_q || (hs && !hs_q);
    v_ok       = v_seen_q || (vs && !vs_q);
    x          = hcnt - H_LEAD;
    y          = lcnt - V_LEAD;
    active     = (x >= 0) && (x < H_ACTIVE) && (y >= 0) && (y < V_ACTIVE);
    border     = (x == 0) || (x == H_ACTIVE - 1) || (y == 0) || (y == V_ACTIVE - 1);
  end

  // expected pixel from the active model set
  always_comb begin
    rx  = int'(act_w[2][11:0]);
    ry  = int'(act_w[2][27:16]);
    rw  = int'(act_w[3][5:0]);
    rh  = int'(act_w[3][21:16]);
    hit = act_w[0][0] && (x >= rx) && (x < rx + rw) && (y >= ry) && (y < ry + rh);
    if (!active) begin
      exp_color = 12'h000;
    end else if (hit) begin
      exp_color = act_w[4][11:0];
    end else if (border) begin
      exp_color = 12'hFFF;
    end else begin
      exp_color = act_w[1][11:0];
    end
  end

  // decode of an incoming write
  always_comb begin
    lanes  = {{8{axil_req.w_strb[3]}}, {8{axil_req.w_strb[2]}},
              {8{axil_req.w_strb[1]}}, {8{axil_req.w_strb[0]}}};
    wr_idx = -1;
    field  = 32'h0;
    case (axil_req.aw_addr)
      8'h00: begin
        wr_idx = 0;
        field  = 32'h0000_0001;
      end
      8'h04: begin
        wr_idx = 1;
        field  = 32'h0000_0FFF;
      end
      8'h08: begin
        wr_idx = 2;
        field  = 32'h0FFF_0FFF;
      end
      8'h0C: begin
        wr_idx = 3;
        field  = 32'h003F_003F;
      end
      8'h10: begin
        wr_idx = 4;
        field  = 32'h0000_0FFF;
      end
      default: wr_idx = -1;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hs_q     <= 1'b0;
      vs_q     <= 1'b0;
      h_seen_q <= 1'b0;
      v_seen_q <= 1'b0;
      hcnt_q   <= 0;
      lcnt_q   <= 0;
      stage_w  <= '{32'h0, 32'h036, 32'h0, 32'h0, 32'hF00};
      act_w    <= '{32'h0, 32'h036, 32'h0, 32'h0, 32'hF00};
    end else begin
      hs_q     <= hs;
      vs_q     <= vs;
      h_seen_q <= h_ok;
      v_seen_q <= v_ok;
      hcnt_q   <= hcnt;
      lcnt_q   <= lcnt;
      // accepted write lands in the staging image
      if (axil_rsp.aw_ready && axil_rsp.w_ready && axil_req.aw_valid && axil_req.w_valid &&
          wr_idx >= 0) begin
        stage_w[wr_idx] <= ((stage_w[wr_idx] & ~lanes) | (axil_req.w_data & lanes)) & field;
      end
      // new picture settings from each vs rise
      if (vs && !vs_q) begin
        act_w <= stage_w;
      end
    end
  end

  reset_idle: assert property (@(posedge pclk) rst |=>
      (!hs && !vs && r == 4'd0 && g == 4'd0 && b == 4'd0 &&
       !axil_rsp.aw_ready && !axil_rsp.w_ready && !axil_rsp.b_valid &&
       !axil_rsp.ar_ready && !axil_rsp.r_valid))
    else begin
      $error("outputs or handshake signals not idle after reset");
      fail_count++;
    end

  // address and data channels accepted together
  ready_pair: assert property (@(posedge pclk) disable iff (rst)
      axil_rsp.aw_ready == axil_rsp.w_ready)
    else begin
      $error("mismatch w_ready got %h expected %h", $sampled(axil_rsp.w_ready),
             $sampled(axil_rsp.aw_ready));
      fail_count++;
    end

  hs_width: assert property (@(posedge pclk) disable iff (rst)
      h_ok |-> (hs == (hcnt < H_SYNC)))
    else begin
      $error("mismatch hs got %h expected %h", $sampled(hs), $sampled(hcnt < H_SYNC));
      fail_count++;
    end

  hs_period: assert property (@(posedge pclk) disable iff (rst)
      (hs && !hs_q && h_seen_q) |-> (hcnt_q == H_TOTAL - 1))
    else begin
      $error("hs rose after %0d cycles instead of one line", $sampled(hcnt_q) + 1);
      fail_count++;
    end

  vs_width: assert property (@(posedge pclk) disable iff (rst)
      (h_ok && v_ok) |-> (vs == (lcnt < V_SYNC)))
    else begin
      $error("mismatch vs got %h expected %h", $sampled(vs), $sampled(lcnt < V_SYNC));
      fail_count++;
    end

  vs_period: assert property (@(posedge pclk) disable iff (rst)
      (vs && !vs_q && h_ok) |-> (line_start && (!v_seen_q || lcnt_q == V_TOTAL - 1)))
    else begin
      $error("vs rose away from a line start or after the wrong number of lines");
      fail_count++;
    end

  pixel_color: assert property (@(posedge pclk) disable iff (rst)
      (h_ok && v_ok) |-> ({r, g, b} == exp_color))
    else begin
      $error("mismatch rgb got %h expected %h", $sampled({r, g, b}), $sampled(exp_color));
      fail_count++;
    end

  // responses hold still under back-pressure
  b_hold: assert property (@(posedge pclk) disable iff (rst)
      (axil_rsp.b_valid && !axil_req.b_ready) |=>
      (axil_rsp.b_valid && $stable(axil_rsp.b_resp)))
    else begin
      $error("write response dropped or changed while b_ready was low");
      fail_count++;
    end

  r_hold: assert property (@(posedge pclk) disable iff (rst)
      (axil_rsp.r_valid && !axil_req.r_ready) |=>
      (axil_rsp.r_valid && $stable(axil_rsp.r_data) && $stable(axil_rsp.r_resp)))
    else begin
      $error("read response dropped or changed while r_ready was low");
      fail_count++;
    end

endmodule

bind voltmeter_top voltmeter_asserts #(
  .H_ACTIVE (H_ACTIVE),
  .H_FRONT  (H_FRONT),
  .H_SYNC   (H_SYNC),
  .H_BACK   (H_BACK),
  .V_ACTIVE (V_ACTIVE),
  .V_FRONT  (V_FRONT),
  .V_SYNC   (V_SYNC),
  .V_BACK   (V_BACK)
) asserts_i (
  .pclk     (pclk),
  .rst      (rst),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .hs       (hs),
  .vs       (vs),
  .r        (r),
  .g        (g),
  .b        (b)
);

/* logic/voltmeter_top.sv */
module voltmeter_top import vga_pkg::*; #(
  parameter int H_ACTIVE = 800,
  parameter int H_FRONT  = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BACK   = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BACK   = 23
) (
  input  logic       pclk,
  input  logic       rst,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  output logic       hs,
  output logic       vs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  vga_timing_t timing;
  logic        frame_start;
  draw_cfg_t   cfg;
  vga_pixel_t  pixel_bg;
  vga_pixel_t  pixel_rect;

  // raster counters
  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) timing_i (
    .pclk        (pclk),
    .rst         (rst),
    .timing      (timing),
    .frame_start (frame_start)
  );

  // host registers, swapped in at frame start
  vga_regs regs_i (
    .pclk        (pclk),
    .rst         (rst),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .frame_start (frame_start),
    .cfg         (cfg)
  );

  // stage 1, border and background
  draw_background #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) background_i (
    .pclk     (pclk),
    .rst      (rst),
    .timing   (timing),
    .bg_color (cfg.bg_color),
    .pixel    (pixel_bg)
  );

  // stage 2, rectangle overlay
  draw_rect rect_i (
    .pclk     (pclk),
    .rst      (rst),
    .pixel_in (pixel_bg),
    .cfg      (cfg),
    .pixel    (pixel_rect)
  );

  // output register, third cycle after the timing generator
  always_ff @(posedge pclk) begin
    if (rst) begin
      hs <= 1'b0;
      vs <= 1'b0;
      r  <= 4'd0;
      g  <= 4'd0;
      b  <= 4'd0;
    end else begin
      hs <= pixel_rect.timing.hsync;
      vs <= pixel_rect.timing.vsync;
      r  <= pixel_rect.color.r;
      g  <= pixel_rect.color.g;
      b  <= pixel_rect.color.b;
    end
  end

endmodule

/* logic/draw_rect.sv */
module draw_rect import vga_pkg::*; (
  input  logic       pclk,
  input  logic       rst,
  input  vga_pixel_t pixel_in,
  input  draw_cfg_t  cfg,
  output vga_pixel_t pixel
);

  // exclusive right and bottom edges, one extra bit so no wrap
  logic [12:0] x_end;
  logic [12:0] y_end;
  logic        in_x;
  logic        in_y;
  logic        active;
  logic        hit;

  assign x_end = {1'b0, cfg.rect_x} + 13'(cfg.rect_w);
  assign y_end = {1'b0, cfg.rect_y} + 13'(cfg.rect_h);

  // zero width or height leaves both windows empty
  assign in_x = (pixel_in.timing.hcount >= cfg.rect_x) &&
                ({1'b0, pixel_in.timing.hcount} < x_end);
  assign in_y = (pixel_in.timing.vcount >= cfg.rect_y) &&
                ({1'b0, pixel_in.timing.vcount} < y_end);

  assign active = !pixel_in.timing.hblnk && !pixel_in.timing.vblnk;
  assign hit    = cfg.rect_en && active && in_x && in_y;

  // rectangle painted over border and background
  always_ff @(posedge pclk) begin
    if (rst) begin
      pixel <= '0;
    end else begin
      pixel.timing <= pixel_in.timing;
      pixel.color  <= hit ? cfg.rect_color : pixel_in.color;
    end
  end

endmodule

/* logic/draw_background.sv */
module draw_background import vga_pkg::*; #(
  parameter int H_ACTIVE = 800,
  parameter int V_ACTIVE = 600
) (
  input  logic        pclk,
  input  logic        rst,
  input  vga_timing_t timing,
  input  rgb_t        bg_color,
  output vga_pixel_t  pixel
);

  // last active column and line
  localparam logic [11:0] H_EDGE = 12'(H_ACTIVE - 1);
  localparam logic [11:0] V_EDGE = 12'(V_ACTIVE - 1);

  logic on_border;
  rgb_t color_nxt;

  assign on_border = (timing.hcount == 12'd0) || (timing.hcount == H_EDGE) ||
                     (timing.vcount == 12'd0) || (timing.vcount == V_EDGE);

  always_comb begin
    // black during blanking
    if (timing.hblnk || timing.vblnk) begin
      color_nxt = '0;
    end else if (on_border) begin
      color_nxt = BORDER_COLOR;
    end else begin
      color_nxt = bg_color;
    end
  end

  // timing forwarded with the colour
  always_ff @(posedge pclk) begin
    if (rst) begin
      pixel <= '0;
    end else begin
      pixel.timing <= timing;
      pixel.color  <= color_nxt;
    end
  end

endmodule

/* logic/vga_regs.sv */
module vga_regs import vga_pkg::*; (
  input  logic      pclk,
  input  logic      rst,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  logic      frame_start,
  output draw_cfg_t cfg
);

  // host-visible staging set
  draw_cfg_t   stage;

  // write channel
  logic        aw_ready_q;
  logic        b_valid_q;
  logic [1:0]  b_resp_q;
  logic        wr_fire;
  logic [31:0] wr_word;

  // read channel
  logic        ar_ready_q;
  logic        r_valid_q;
  logic [31:0] r_data_q;
  logic [1:0]  r_resp_q;
  logic        rd_fire;

  // address inside the map
  function automatic logic addr_hit(input logic [7:0] addr);
    return (addr == REG_CTRL) || (addr == REG_BG_COLOR) || (addr == REG_RECT_POS) ||
           (addr == REG_RECT_SIZE) || (addr == REG_RECT_COLOR);
  endfunction

  // 32-bit image of one register, zero for unmapped
  function automatic logic [31:0] reg_word(input logic [7:0] addr, input draw_cfg_t c);
    logic [31:0] word;
    word = '0;
    case (addr)
      REG_CTRL:       word[0]     = c.rect_en;
      REG_BG_COLOR:   word[11:0]  = c.bg_color;
      REG_RECT_POS: begin
        word[11:0]  = c.rect_x;
        word[27:16] = c.rect_y;
      end
      REG_RECT_SIZE: begin
        word[5:0]   = c.rect_w;
        word[21:16] = c.rect_h;
      end
      REG_RECT_COLOR: word[11:0]  = c.rect_color;
      default:        word        = '0;
    endcase
    return word;
  endfunction

  // byte lanes with strobe set take new data
  function automatic logic [31:0] merge_strb(
    input logic [31:0] old_word,
    input logic [31:0] data,
    input logic [3:0]  strb
  );
    logic [31:0] word;
    int          i;
    word = old_word;
    for (i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    return word;
  endfunction

  assign wr_fire = aw_ready_q && axil_req.aw_valid && axil_req.w_valid;
  assign rd_fire = ar_ready_q && axil_req.ar_valid;

  assign wr_word = merge_strb(reg_word(axil_req.aw_addr, stage), axil_req.w_data,
                              axil_req.w_strb);

  // handshake state
  always_ff @(posedge pclk) begin
    if (rst) begin
      aw_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      // one-cycle ready pulse, held off while a response waits
      aw_ready_q <= axil_req.aw_valid && axil_req.w_valid && !aw_ready_q && !b_valid_q;
      ar_ready_q <= axil_req.ar_valid && !ar_ready_q && !r_valid_q;
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (axil_req.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (axil_req.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // response payload, stable while valid is held
  always_ff @(posedge pclk) begin
    if (wr_fire) begin
      b_resp_q <= addr_hit(axil_req.aw_addr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_data_q <= reg_word(axil_req.ar_addr, stage);
      r_resp_q <= addr_hit(axil_req.ar_addr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // staging writes, unmapped addresses fall through untouched
  always_ff @(posedge pclk) begin
    if (rst) begin
      stage <= CFG_RESET;
    end else if (wr_fire) begin
      case (axil_req.aw_addr)
        REG_CTRL:       stage.rect_en    <= wr_word[0];
        REG_BG_COLOR:   stage.bg_color   <= wr_word[11:0];
        REG_RECT_POS: begin
          stage.rect_x <= wr_word[11:0];
          stage.rect_y <= wr_word[27:16];
        end
        REG_RECT_SIZE: begin
          stage.rect_w <= wr_word[5:0];
          stage.rect_h <= wr_word[21:16];
        end
        REG_RECT_COLOR: stage.rect_color <= wr_word[11:0];
        default:        stage            <= stage;
      endcase
    end
  end

  // active set only moves at the frame boundary
  always_ff @(posedge pclk) begin
    if (rst) begin
      cfg <= CFG_RESET;
    end else if (frame_start) begin
      cfg <= stage;
    end
  end

  always_comb begin
    axil_rsp.aw_ready = aw_ready_q;
    axil_rsp.w_ready  = aw_ready_q;
    axil_rsp.b_valid  = b_valid_q;
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = ar_ready_q;
    axil_rsp.r_valid  = r_valid_q;
    axil_rsp.r_data   = r_data_q;
    axil_rsp.r_resp   = r_resp_q;
  end

endmodule

/* logic/vga_timing.sv */
module vga_timing import vga_pkg::*; #(
  parameter int H_ACTIVE = 800,
  parameter int H_FRONT  = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BACK   = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BACK   = 23
) (
  input  logic        pclk,
  input  logic        rst,
  output vga_timing_t timing,
  output logic        frame_start
);

  // line and frame lengths
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam logic [11:0] H_LAST = 12'(H_TOTAL - 1);
  localparam logic [11:0] V_LAST = 12'(V_TOTAL - 1);

  // sync windows, start inclusive and end exclusive
  localparam logic [11:0] H_SYNC_START = 12'(H_ACTIVE + H_FRONT);
  localparam logic [11:0] H_SYNC_END   = 12'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [11:0] V_SYNC_START = 12'(V_ACTIVE + V_FRONT);
  localparam logic [11:0] V_SYNC_END   = 12'(V_ACTIVE + V_FRONT + V_SYNC);

  localparam logic [11:0] H_ACT = 12'(H_ACTIVE);
  localparam logic [11:0] V_ACT = 12'(V_ACTIVE);

  logic [11:0] h_next;
  logic [11:0] v_next;

  // flags derived from a pair of counts
  function automatic vga_timing_t decode(input logic [11:0] h, input logic [11:0] v);
    vga_timing_t t;
    t.hcount = h;
    t.vcount = v;
    t.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_END);
    t.vsync  = (v >= V_SYNC_START) && (v < V_SYNC_END);
    t.hblnk  = (h >= H_ACT);
    t.vblnk  = (v >= V_ACT);
    return t;
  endfunction

  // pixel counter wraps at line end, line counter steps on wrap
  always_comb begin
    h_next = timing.hcount + 12'd1;
    v_next = timing.vcount;
    if (timing.hcount == H_LAST) begin
      h_next = 12'd0;
      if (timing.vcount == V_LAST) begin
        v_next = 12'd0;
      end else begin
        v_next = timing.vcount + 12'd1;
      end
    end
  end

  // counts and flags registered together
  always_ff @(posedge pclk) begin
    if (rst) begin
      timing      <= decode(12'd0, 12'd0);
      frame_start <= 1'b0;
    end else begin
      timing      <= decode(h_next, v_next);
      // aligned with first pixel of first vsync line
      frame_start <= (h_next == 12'd0) && (v_next == V_SYNC_START);
    end
  end

endmodule

/* logic/vga_pkg.sv */
package vga_pkg;

  // 4 bits per channel, red in the top nibble
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // raster state that travels with every pixel
  typedef struct packed {
    logic [11:0] hcount;
    logic [11:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
  } vga_timing_t;

  // output of each drawing stage
  typedef struct packed {
    vga_timing_t timing;
    rgb_t        color;
  } vga_pixel_t;

  // picture settings seen by the drawing stages
  typedef struct packed {
    rgb_t        bg_color;
    logic        rect_en;
    logic [11:0] rect_x;
    logic [11:0] rect_y;
    logic [5:0]  rect_w;
    logic [5:0]  rect_h;
    rgb_t        rect_color;
  } draw_cfg_t;

  // host-driven axi4-lite signals
  typedef struct packed {
    logic [7:0]  aw_addr;
    logic        aw_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_valid;
    logic        b_ready;
    logic [7:0]  ar_addr;
    logic        ar_valid;
    logic        r_ready;
  } axil_req_t;

  // slave-driven axi4-lite signals
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  // register map
  localparam logic [7:0] REG_CTRL       = 8'h00;
  localparam logic [7:0] REG_BG_COLOR   = 8'h04;
  localparam logic [7:0] REG_RECT_POS   = 8'h08;
  localparam logic [7:0] REG_RECT_SIZE  = 8'h0C;
  localparam logic [7:0] REG_RECT_COLOR = 8'h10;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // one-pixel frame around the active area
  localparam rgb_t BORDER_COLOR = 12'hFFF;

  // power-up picture, dark teal with a red rectangle colour
  localparam rgb_t RESET_BG_COLOR   = 12'h036;
  localparam rgb_t RESET_RECT_COLOR = 12'hF00;

  localparam draw_cfg_t CFG_RESET = '{
    bg_color:   RESET_BG_COLOR,
    rect_en:    1'b0,
    rect_x:     12'd0,
    rect_y:     12'd0,
    rect_w:     6'd0,
    rect_h:     6'd0,
    rect_color: RESET_RECT_COLOR
  };

endpackage
